// ==== hw/mm_settings.svh ====
//##################################################
// Matrix-multiply engine settings
// Element, word and matrix sizes plus bank depths
//##################################################
`ifndef MM_SETTINGS_SVH
`define MM_SETTINGS_SVH

// Signed element width
`define MM_ELEM_W    8
// Elements packed into one bank word
`define MM_BLOCK     2

// C = A x B, A is ROWS_A x INNER, B is INNER x COLS_B
`define MM_ROWS_A    4
`define MM_INNER     4
`define MM_COLS_B    3
// Words per A row or per B column
`define MM_WORDS     (`MM_INNER / `MM_BLOCK)

// Bank depths in words
`define MM_W_DEPTH   8
`define MM_N_DEPTH   6
`define MM_W_ADDR_W  3
`define MM_N_ADDR_W  3

// Index widths of C rows, C columns and words in a dot product
`define MM_ROW_W     2
`define MM_COL_W     2
`define MM_WORD_W    1

// Accumulator and result width
`define MM_ACC_W     20

`endif

// ==== hw/mm_pkg.sv ====
//##################################################
// Matrix-multiply engine types
// Controller states, data words and issue tags
//##################################################
`default_nettype none

`include "mm_settings.svh"

package mm_pkg;

    // One signed operand element
    typedef logic signed [`MM_ELEM_W-1:0] elem_t;

    // Packed word of BLOCK elements, element 0 in the low bits
    // Elements keep their sign through the named element type
    typedef elem_t [`MM_BLOCK-1:0] word_t;

    // Signed partial sum and final C element
    typedef logic signed [`MM_ACC_W-1:0] acc_t;

    // Decode stage states
    typedef enum logic [1:0] {
        st_idle,
        st_load_n,
        st_compute,
        st_done
    } ctrl_state_t;

    // Tag that follows each word pair down the pipeline
    typedef struct packed {
        logic [`MM_ROW_W-1:0] row;
        logic [`MM_COL_W-1:0] col;
        // Final word of this C element's dot product
        logic                 last;
    } mac_tag_t;

endpackage

`default_nettype wire

// ==== hw/operand_bank_if.sv ====
//##################################################
// Operand bank control bundle
// Port A write controls and port B read controls
//##################################################
`timescale 1ns/100ps
`default_nettype none

interface operand_bank_if #(
    parameter int ADDR_W = 3
);

    // Port A, write side
    logic              ena;
    logic              wea;
    logic [ADDR_W-1:0] addra;

    // Port B, registered read side
    logic              enb;
    logic [ADDR_W-1:0] addrb;

    // Driven by the decode stage
    modport ctrl (
        output ena,
        output enb,
        output wea,
        output addra,
        output addrb
    );

    modport bank (
        input ena,
        input enb,
        input wea,
        input addra,
        input addrb
    );

endinterface

`default_nettype wire

// ==== hw/operand_bank.sv ====
//##################################################
// Operand bank
// Dual-port word memory, synchronous write port A
// and registered read port B
//##################################################
`timescale 1ns/100ps
`default_nettype none

module operand_bank
    import mm_pkg::*;
#(
    parameter int DEPTH  = 8,
    parameter int ADDR_W = 3
) (
    input  wire logic  clk,
    operand_bank_if.bank ctrl,
    input  wire word_t wdata,
    output word_t      rdata
);

    word_t mem [DEPTH];

    // Addresses sized to this bank
    logic [ADDR_W-1:0] wr_addr;
    logic [ADDR_W-1:0] rd_addr;

    assign wr_addr = ctrl.addra;
    assign rd_addr = ctrl.addrb;

    // Port A writes in the cycle of the strobe
    always_ff @(posedge clk) begin
        if (ctrl.ena && ctrl.wea) begin
            mem[wr_addr] <= wdata;
        end
    end

    // Port B holds its last word while not enabled
    always_ff @(posedge clk) begin
        if (ctrl.enb) begin
            rdata <= mem[rd_addr];
        end
    end

endmodule

`default_nettype wire

// ==== hw/buffer_ctrl.sv ====
//##################################################
// Decode stage of the matrix-multiply engine
// Bank write/read control, A row tracking and
// row-major issue of dot-product word pairs
//##################################################
`timescale 1ns/100ps
`default_nettype none

`include "mm_settings.svh"

module buffer_ctrl
    import mm_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    rst_n,
    input  wire logic    w_valid,
    input  wire logic    n_valid,
    operand_bank_if.ctrl w_bank,
    operand_bank_if.ctrl n_bank,
    output logic         issue,
    output mac_tag_t     tag,
    output logic         busy
);

    localparam int WORDS  = `MM_WORDS;
    localparam int W_AW   = `MM_W_ADDR_W;
    localparam int N_AW   = `MM_N_ADDR_W;
    localparam int ROW_W  = `MM_ROW_W;
    localparam int COL_W  = `MM_COL_W;
    localparam int WORD_W = `MM_WORD_W;
    // Wide enough to hold a count of all A rows
    localparam int RDY_W  = $clog2(`MM_ROWS_A + 1);

    ctrl_state_t state;
    ctrl_state_t state_next;

    // Write side
    logic              w_wr_en;
    logic              n_wr_en;
    logic [W_AW-1:0]   w_wr_addr;
    logic [N_AW-1:0]   n_wr_addr;
    logic [WORD_W-1:0] w_wr_word;
    logic              w_row_end;
    logic [RDY_W-1:0]  rows_ready;

    // Read side
    logic [ROW_W-1:0]  rd_row;
    logic [COL_W-1:0]  rd_col;
    logic [WORD_W-1:0] rd_word;
    logic [W_AW-1:0]   w_rd_addr;
    logic [N_AW-1:0]   n_rd_addr;
    logic              active;
    logic              row_ok;
    logic              col_ok;
    logic              word_last;
    logic              col_last;
    logic              row_last;
    logic              run_last;

    assign active = (state == st_load_n) || (state == st_compute);
    assign busy   = (state != st_idle);

    // West words are taken in any state but done, until A is full
    assign w_wr_en   = w_valid && (state != st_done) && (rows_ready < RDY_W'(`MM_ROWS_A));
    // North words only until B is complete
    assign n_wr_en   = n_valid && ((state == st_idle) || (state == st_load_n));
    assign w_row_end = (w_wr_word == WORD_W'(WORDS - 1));

    // Row-major read addresses
    assign w_rd_addr = W_AW'(rd_row * WORDS + rd_word);
    assign n_rd_addr = N_AW'(rd_col * WORDS + rd_word);

    // Current A row fully written
    assign row_ok = (rows_ready > RDY_W'(rd_row));
    // While B is still loading, only read north words already written
    assign col_ok = (state == st_compute) || (n_rd_addr < n_wr_addr);

    assign issue = active && row_ok && col_ok;

    assign word_last = (rd_word == WORD_W'(WORDS - 1));
    assign col_last  = (rd_col == COL_W'(`MM_COLS_B - 1));
    assign row_last  = (rd_row == ROW_W'(`MM_ROWS_A - 1));
    // Final word of the final C element
    assign run_last  = issue && word_last && col_last && row_last;

    assign tag = '{row: rd_row, col: rd_col, last: word_last};

    // West bank controls
    assign w_bank.ena   = w_valid && (state != st_done);
    assign w_bank.wea   = w_wr_en;
    assign w_bank.addra = w_wr_addr;
    assign w_bank.enb   = issue;
    assign w_bank.addrb = w_rd_addr;

    // North bank controls
    assign n_bank.ena   = n_valid && (state != st_done);
    assign n_bank.wea   = n_wr_en;
    assign n_bank.addra = n_wr_addr;
    assign n_bank.enb   = issue;
    assign n_bank.addrb = n_rd_addr;

    // Next state
    always_comb begin
        state_next = state;
        case (state)
            st_idle: begin
                if (n_valid) begin
                    state_next = st_load_n;
                end
            end
            st_load_n: begin
                // Last north word goes in this cycle
                if (n_wr_en && (n_wr_addr == N_AW'(`MM_N_DEPTH - 1))) begin
                    state_next = st_compute;
                end
            end
            st_compute: begin
                if (run_last) begin
                    state_next = st_done;
                end
            end
            st_done: begin
                // Held until reset
                state_next = st_done;
            end
            default: begin
                state_next = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= st_idle;
            w_wr_addr  <= '0;
            w_wr_word  <= '0;
            rows_ready <= '0;
            n_wr_addr  <= '0;
            rd_row     <= '0;
            rd_col     <= '0;
            rd_word    <= '0;
        end else begin
            state <= state_next;

            // West write address, one more ready row per completed row
            if (w_wr_en) begin
                w_wr_addr <= w_wr_addr + 1'b1;
                if (w_row_end) begin
                    w_wr_word  <= '0;
                    rows_ready <= rows_ready + 1'b1;
                end else begin
                    w_wr_word <= w_wr_word + 1'b1;
                end
            end

            if (n_wr_en) begin
                n_wr_addr <= n_wr_addr + 1'b1;
            end

            // Word, then column, then row
            if (issue) begin
                if (word_last) begin
                    rd_word <= '0;
                    if (col_last) begin
                        rd_col <= '0;
                        rd_row <= row_last ? '0 : rd_row + 1'b1;
                    end else begin
                        rd_col <= rd_col + 1'b1;
                    end
                end else begin
                    rd_word <= rd_word + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/block_mac.sv ====
//##################################################
// Execute stage
// Element-wise multiply and adder tree of one word
// pair, tag carried alongside
//##################################################
`timescale 1ns/100ps
`default_nettype none

`include "mm_settings.svh"

module block_mac
    import mm_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     rst_n,
    input  wire logic     issue,
    input  wire mac_tag_t tag,
    input  wire word_t    a_word,
    input  wire word_t    b_word,
    output logic          partial_valid,
    output acc_t          partial,
    output mac_tag_t      partial_tag
);

    localparam int PROD_W = 2 * `MM_ELEM_W;

    typedef logic signed [PROD_W-1:0] prod_t;

    // Stage 0 lines up with the bank read registers
    logic     s0_valid;
    mac_tag_t s0_tag;

    // Stage 1 holds the element products
    logic     s1_valid;
    mac_tag_t s1_tag;
    prod_t    prod [`MM_BLOCK];

    // Sum of all products, before the output register
    acc_t     prod_sum;

    // Valid bits
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s0_valid      <= 1'b0;
            s1_valid      <= 1'b0;
            partial_valid <= 1'b0;
        end else begin
            s0_valid      <= issue;
            s1_valid      <= s0_valid;
            partial_valid <= s1_valid;
        end
    end

    // Tags ride with the data
    always_ff @(posedge clk) begin
        s0_tag      <= tag;
        s1_tag      <= s0_tag;
        partial_tag <= s1_tag;
    end

    // Signed products of the element pairs
    always_ff @(posedge clk) begin
        if (s0_valid) begin
            for (int i = 0; i < `MM_BLOCK; i++) begin
                prod[i] <= $signed(a_word[i]) * $signed(b_word[i]);
            end
        end
    end

    // Adder tree, products sign-extended to the result width
    always_comb begin
        prod_sum = '0;
        for (int i = 0; i < `MM_BLOCK; i++) begin
            prod_sum = prod_sum + acc_t'(prod[i]);
        end
    end

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            partial <= prod_sum;
        end
    end

endmodule

`default_nettype wire

// ==== hw/result_accum.sv ====
//##################################################
// Result stage
// Sums partials per C element, emits each element
// with its row and column, then raises done
//##################################################
`timescale 1ns/100ps
`default_nettype none

`include "mm_settings.svh"

module result_accum
    import mm_pkg::*;
(
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic              partial_valid,
    input  wire acc_t              partial,
    input  wire mac_tag_t          partial_tag,
    input  wire logic              busy,
    output logic                   c_valid,
    output acc_t                   c_data,
    output logic [`MM_ROW_W-1:0]   c_row,
    output logic [`MM_COL_W-1:0]   c_col,
    output logic                   done
);

    // Running sum of the current C element
    acc_t run_sum;
    logic final_out;

    // Last element of C in row-major order
    assign final_out = c_valid
                    && (c_row == `MM_ROW_W'(`MM_ROWS_A - 1))
                    && (c_col == `MM_COL_W'(`MM_COLS_B - 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            run_sum <= '0;
            c_valid <= 1'b0;
            done    <= 1'b0;
        end else begin
            c_valid <= 1'b0;
            if (partial_valid) begin
                if (partial_tag.last) begin
                    c_valid <= 1'b1;
                    run_sum <= '0;
                end else begin
                    run_sum <= run_sum + partial;
                end
            end else if (!busy) begin
                // Controller idle, start from zero
                run_sum <= '0;
            end
            // Sticky until reset
            if (final_out) begin
                done <= 1'b1;
            end
        end
    end

    // Finished element with its position
    always_ff @(posedge clk) begin
        if (partial_valid && partial_tag.last) begin
            c_data <= run_sum + partial;
            c_row  <= partial_tag.row;
            c_col  <= partial_tag.col;
        end
    end

endmodule

`default_nettype wire

// ==== hw/matmul_top.sv ====
//##################################################
// Tiled matrix-multiply engine, C = A x B
// Decode, two operand banks, execute and result
//##################################################
`timescale 1ns/100ps
`default_nettype none

`include "mm_settings.svh"

module matmul_top
    import mm_pkg::*;
(
    input  wire logic            clk,
    input  wire logic            rst_n,
    input  wire logic            w_valid,
    input  wire word_t           w_data,
    input  wire logic            n_valid,
    input  wire word_t           n_data,
    output logic                 c_valid,
    output acc_t                 c_data,
    output logic [`MM_ROW_W-1:0] c_row,
    output logic [`MM_COL_W-1:0] c_col,
    output logic                 done
);

    // Bank control bundles, one per operand
    operand_bank_if #(.ADDR_W(`MM_W_ADDR_W)) w_bus ();
    operand_bank_if #(.ADDR_W(`MM_N_ADDR_W)) n_bus ();

    logic     issue;
    mac_tag_t tag;
    logic     busy;
    word_t    a_word;
    word_t    b_word;
    logic     partial_valid;
    acc_t     partial;
    mac_tag_t partial_tag;

    buffer_ctrl u_ctrl (
        .clk     (clk),
        .rst_n   (rst_n),
        .w_valid (w_valid),
        .n_valid (n_valid),
        .w_bank  (w_bus.ctrl),
        .n_bank  (n_bus.ctrl),
        .issue   (issue),
        .tag     (tag),
        .busy    (busy)
    );

    // West bank holds A row-major
    operand_bank #(.DEPTH(`MM_W_DEPTH), .ADDR_W(`MM_W_ADDR_W)) u_w_bank (
        .clk   (clk),
        .ctrl  (w_bus.bank),
        .wdata (w_data),
        .rdata (a_word)
    );

    // North bank holds B column by column
    operand_bank #(.DEPTH(`MM_N_DEPTH), .ADDR_W(`MM_N_ADDR_W)) u_n_bank (
        .clk   (clk),
        .ctrl  (n_bus.bank),
        .wdata (n_data),
        .rdata (b_word)
    );

    block_mac u_mac (
        .clk           (clk),
        .rst_n         (rst_n),
        .issue         (issue),
        .tag           (tag),
        .a_word        (a_word),
        .b_word        (b_word),
        .partial_valid (partial_valid),
        .partial       (partial),
        .partial_tag   (partial_tag)
    );

    result_accum u_accum (
        .clk           (clk),
        .rst_n         (rst_n),
        .partial_valid (partial_valid),
        .partial       (partial),
        .partial_tag   (partial_tag),
        .busy          (busy),
        .c_valid       (c_valid),
        .c_data        (c_data),
        .c_row         (c_row),
        .c_col         (c_col),
        .done          (done)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_clock_gen.sv ====
//##################################################
// Testbench clock and reset source
// Reset held low for a fixed cycle count at start
// and again whenever a reset is requested
//##################################################
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD     = 8,
    parameter int RST_CYCLES = 4
) (
    input  wire logic reset_req,
    output logic      clk,
    output logic      rst_n
);

    // Reset cycles still to go
    int rst_left;

    initial begin
        clk      = 1'b0;
        rst_n    = 1'b0;
        rst_left = RST_CYCLES;
    end

    always #(PERIOD / 2) clk = ~clk;

    // Count down, restart on request
    always @(posedge clk) begin
        if (reset_req) begin
            rst_n    <= 1'b0;
            rst_left <= RST_CYCLES;
        end else if (rst_left > 1) begin
            rst_left <= rst_left - 1;
        end else if (rst_left == 1) begin
            rst_left <= 0;
            rst_n    <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== testbench/tb_matmul.sv ====
//##################################################
// Testbench of the matrix-multiply engine
// Random, interleaved and extreme runs checked
// against a reference model of C = A x B
//##################################################
`timescale 1ns/100ps
`default_nettype none

`include "mm_settings.svh"

module tb_matmul
    import mm_pkg::*;
;

    localparam int ROWS    = `MM_ROWS_A;
    localparam int INNER   = `MM_INNER;
    localparam int COLS    = `MM_COLS_B;
    localparam int BLOCK   = `MM_BLOCK;
    localparam int WORDS   = `MM_WORDS;
    localparam int W_DEPTH = `MM_W_DEPTH;
    localparam int N_DEPTH = `MM_N_DEPTH;
    localparam int LCG_SEED = 66;
    // Random, interleaved, three extreme runs and the run after reset
    localparam int RUNS       = 6;
    localparam int RUN_CYCLES = W_DEPTH + N_DEPTH + ROWS * COLS * 2 + 40;

    logic                 clk;
    logic                 rst_n;
    logic                 reset_req;
    logic                 w_valid;
    word_t                w_data;
    logic                 n_valid;
    word_t                n_data;
    logic                 c_valid;
    acc_t                 c_data;
    logic [`MM_ROW_W-1:0] c_row;
    logic [`MM_COL_W-1:0] c_col;
    logic                 done;

    // Operand matrices of the current run
    elem_t       a_mat [ROWS][INNER];
    elem_t       b_mat [INNER][COLS];
    // Expected C elements, row-major
    longint      exp_data [$];
    int          exp_row [$];
    int          exp_col [$];
    logic [31:0] lcg_state;

    tb_clock_gen #(.PERIOD(8), .RST_CYCLES(4)) u_clk_gen (
        .reset_req (reset_req),
        .clk       (clk),
        .rst_n     (rst_n)
    );

    matmul_top UUT (
        .clk     (clk),
        .rst_n   (rst_n),
        .w_valid (w_valid),
        .w_data  (w_data),
        .n_valid (n_valid),
        .n_data  (n_data),
        .c_valid (c_valid),
        .c_data  (c_data),
        .c_row   (c_row),
        .c_col   (c_col),
        .done    (done)
    );

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // Dot product of A row r and B column c
    function automatic longint ref_element(int r, int c);
        longint sum;
        sum = 0;
        for (int k = 0; k < INNER; k++) begin
            sum += longint'(a_mat[r][k]) * longint'(b_mat[k][c]);
        end
        return sum;
    endfunction

    // Word w of A row r, lowest element in the low bits
    function automatic word_t pack_a_word(int r, int w);
        word_t wd;
        for (int i = 0; i < BLOCK; i++) begin
            wd[i] = a_mat[r][w * BLOCK + i];
        end
        return wd;
    endfunction

    // Word w of B column c
    function automatic word_t pack_b_word(int c, int w);
        word_t wd;
        for (int i = 0; i < BLOCK; i++) begin
            wd[i] = b_mat[w * BLOCK + i][c];
        end
        return wd;
    endfunction

    task automatic report_failure();
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic check(input string name, input longint got, input longint exp);
        if (got !== exp) begin
            $display("ERR %s got 0x%0h expected 0x%0h", name, got, exp);
            report_failure();
        end
    endtask

    task automatic build_expected();
        exp_data.delete();
        exp_row.delete();
        exp_col.delete();
        for (int r = 0; r < ROWS; r++) begin
            for (int c = 0; c < COLS; c++) begin
                exp_data.push_back(ref_element(r, c));
                exp_row.push_back(r);
                exp_col.push_back(c);
            end
        end
    endtask

    task automatic fill_random();
        logic [31:0] rnd;
        for (int r = 0; r < ROWS; r++) begin
            for (int k = 0; k < INNER; k++) begin
                rnd = lcg_next();
                a_mat[r][k] = rnd[23:16];
            end
        end
        for (int k = 0; k < INNER; k++) begin
            for (int c = 0; c < COLS; c++) begin
                rnd = lcg_next();
                b_mat[k][c] = rnd[23:16];
            end
        end
        build_expected();
    endtask

    task automatic fill_const(input elem_t a_val, input elem_t b_val);
        foreach (a_mat[r, k]) a_mat[r][k] = a_val;
        foreach (b_mat[k, c]) b_mat[k][c] = b_val;
        build_expected();
    endtask

    // All of B, then all of A, one word per cycle
    task automatic load_b_then_a();
        for (int j = 0; j < N_DEPTH; j++) begin
            @(posedge clk);
            n_valid <= 1'b1;
            n_data  <= pack_b_word(j / WORDS, j % WORDS);
        end
        for (int j = 0; j < W_DEPTH; j++) begin
            @(posedge clk);
            n_valid <= 1'b0;
            w_valid <= 1'b1;
            w_data  <= pack_a_word(j / WORDS, j % WORDS);
        end
        @(posedge clk);
        w_valid <= 1'b0;
    endtask

    // Both streams at random, A rows followed by a gap of 0 to 3 cycles
    task automatic load_interleaved();
        logic [31:0] rnd;
        int          nb;
        int          na;
        int          gap;
        nb  = 0;
        na  = 0;
        gap = 0;
        while ((nb < N_DEPTH) || (na < W_DEPTH)) begin
            @(posedge clk);
            rnd = lcg_next();
            n_valid <= 1'b0;
            w_valid <= 1'b0;
            if ((nb < N_DEPTH) && rnd[20]) begin
                n_valid <= 1'b1;
                n_data  <= pack_b_word(nb / WORDS, nb % WORDS);
                nb++;
            end
            if (gap > 0) begin
                gap--;
            end else if ((na < W_DEPTH) && rnd[21]) begin
                w_valid <= 1'b1;
                w_data  <= pack_a_word(na / WORDS, na % WORDS);
                na++;
                if ((na % WORDS) == 0) begin
                    gap = int'(rnd[25:24]);
                end
            end
        end
        @(posedge clk);
        n_valid <= 1'b0;
        w_valid <= 1'b0;
    endtask

    // done must come only once every element has been seen
    task automatic wait_done();
        while (!done) @(negedge clk);
        check("results left", exp_data.size(), 0);
    endtask

    task automatic do_reset();
        @(posedge clk);
        reset_req <= 1'b1;
        @(posedge clk);
        reset_req <= 1'b0;
        @(posedge clk);
        while (!rst_n) @(posedge clk);
    endtask

    // Strobes after done must be ignored
    task automatic drive_after_done();
        logic [31:0] rnd;
        for (int i = 0; i < 4; i++) begin
            @(posedge clk);
            rnd = lcg_next();
            w_valid <= 1'b1;
            n_valid <= 1'b1;
            w_data  <= rnd[15:0];
            n_data  <= rnd[31:16];
        end
        @(posedge clk);
        w_valid <= 1'b0;
        n_valid <= 1'b0;
        repeat (8) begin
            @(negedge clk);
            check("done", done, 1);
            check("c_valid", c_valid, 0);
        end
    endtask

    // Results in row-major order against the reference
    always @(negedge clk) begin
        if (rst_n && c_valid) begin
            if (exp_data.size() == 0) begin
                $display("Result strobe seen with no C element expected");
                report_failure();
            end else begin
                check("c_row", c_row, exp_row.pop_front());
                check("c_col", c_col, exp_col.pop_front());
                check("c_data", longint'(c_data), exp_data.pop_front());
            end
        end
    end

    initial begin
        repeat (RUNS * RUN_CYCLES) @(posedge clk);
        $display("Timeout: the C results did not complete in %0d cycles", RUNS * RUN_CYCLES);
        report_failure();
    end

    initial begin
        reset_req   = 1'b0;
        w_valid     = 1'b0;
        w_data      = '0;
        n_valid     = 1'b0;
        n_data      = '0;
        lcg_state   = 32'(LCG_SEED);
        @(posedge clk);
        while (!rst_n) @(posedge clk);

        // Quiet until input arrives
        repeat (10) begin
            @(negedge clk);
            check("c_valid", c_valid, 0);
            check("done", done, 0);
        end

        fill_random();
        load_b_then_a();
        wait_done();

        do_reset();
        fill_random();
        load_interleaved();
        wait_done();

        // Largest magnitudes of both signs
        do_reset();
        fill_const(elem_t'(-128), elem_t'(-128));
        load_b_then_a();
        wait_done();
        do_reset();
        fill_const(elem_t'(127), elem_t'(127));
        load_b_then_a();
        wait_done();
        do_reset();
        fill_const(elem_t'(-128), elem_t'(127));
        load_b_then_a();
        wait_done();

        drive_after_done();
        do_reset();
        fill_random();
        load_b_then_a();
        wait_done();

        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+hw
hw/mm_pkg.sv
hw/operand_bank_if.sv
hw/operand_bank.sv
hw/buffer_ctrl.sv
hw/block_mac.sv
hw/result_accum.sv
hw/matmul_top.sv
testbench/tb_clock_gen.sv
testbench/tb_matmul.sv

// ==== Makefile ====
# Verilator build and run of the matrix-multiply testbench

VERILATOR ?= verilator
TOP       ?= tb_matmul
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard hw/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run check clean

all: check

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)

check: run
	@if grep -q '^NO ERRORS$$' $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
